/* rtl/link_pkg.sv */
/*
  Shared definitions for the serial command link.
  Bit timing constants of the 8N1 frame.
  State encodings of the transmitter, receiver, sender and command assembler.
*/
`default_nettype none

package link_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////////////////////////////
  localparam int BAUD_DIV   = 16;                 // Clocks per bit, short for simulation.
  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);   // Width of the bit timer.
  localparam int HALF_BAUD  = BAUD_DIV / 2;       // Mid-bit sample point.
  localparam int FRAME_BITS = 10;                 // Start bit, 8 data bits, stop bit.
  localparam int BIT_CNT_W  = 4;                  // Holds a count up to FRAME_BITS.

  //////////////////////////////////////////////////////////////////////////
  // State encodings
  //////////////////////////////////////////////////////////////////////////
  // Transmitter.
  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;

  // Receiver.
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  // Command sender, high byte goes first.
  typedef enum logic [1:0] {SND_IDLE, SND_HIGH, SND_LOW} snd_state_t;

  // Command assembler on the remote node.
  typedef enum logic {WAIT_HIGH, WAIT_LOW} asm_state_t;

endpackage

`default_nettype wire

/* rtl/uart_tx.sv */
/*
  8N1 serial transmitter.
  Sends a start bit, eight data bits LSB first and a stop bit, BAUD_DIV
  clocks per bit. tx_done holds from frame end until the next trmt.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import link_pkg::*;
(
  input  logic       clk,      // System clock.
  input  logic       rst_n,    // Asynchronous active low reset.
  input  logic       trmt,     // Start a frame with tx_data.
  input  logic [7:0] tx_data,  // Byte to send.
  output logic       tx,       // Serial line, high when idle.
  output logic       tx_done   // Frame finished, sticky until trmt.
);

  tx_state_t             state;      // Frame in flight or not.
  logic [8:0]            tx_shft;    // Data byte above the start bit.
  logic [BAUD_CNT_W-1:0] baud_cnt;   // Clocks spent in the current bit.
  logic [BIT_CNT_W-1:0]  bit_cnt;    // Bits finished in this frame.
  logic                  bit_end;    // Last clock of a bit.
  logic                  frame_end;  // Last clock of the stop bit.

  assign bit_end   = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
  assign frame_end = bit_end && (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

  // Frame state.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= TX_IDLE;
    else if (trmt)
      state <= TX_SHIFT;                  // Start bit goes out next clock.
    else if (state == TX_SHIFT && frame_end)
      state <= TX_IDLE;
  end

  // Bit timer and bit counter.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (state == TX_IDLE) begin
      baud_cnt <= '0;                     // Held clear between frames.
      bit_cnt  <= '0;
    end else if (bit_end) begin
      baud_cnt <= '0;
      bit_cnt  <= bit_cnt + 1'b1;         // Next bit.
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Shift register. Ones fill in from the top and form the stop bit.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_shft <= '1;                      // Line idles high.
    else if (trmt)
      tx_shft <= {tx_data, 1'b0};         // Data over a start bit.
    else if (state == TX_SHIFT && bit_end)
      tx_shft <= {1'b1, tx_shft[8:1]};    // LSB first.
  end

  assign tx = tx_shft[0];

  // Sticky done flag.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_done <= 1'b0;
    else if (trmt)
      tx_done <= 1'b0;                    // New frame knocks it down.
    else if (state == TX_SHIFT && frame_end)
      tx_done <= 1'b1;                    // FRAME_BITS*BAUD_DIV after trmt.
  end

  // The user may only start a frame once the previous one is out.
  trmt_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    trmt |-> state == TX_IDLE)
    else $error("uart_tx: trmt while a frame is in flight");

endmodule

`default_nettype wire

/* rtl/uart_rx.sv */
/*
  8N1 serial receiver.
  Double-flop synchronizer, start detection on a falling edge, mid-bit
  sampling of eight data bits LSB first, and a ready flag set in the stop bit.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import link_pkg::*;
(
  input  logic       clk,         // System clock.
  input  logic       rst_n,       // Asynchronous active low reset.
  input  logic       rx,          // Serial line in, asynchronous.
  input  logic       clr_rx_rdy,  // Consume the received byte.
  output logic [7:0] rx_data,     // Last received byte.
  output logic       rx_rdy       // Byte available.
);

  rx_state_t             state;       // Current state.
  rx_state_t             nxt_state;   // Next state.
  logic                  rx_meta;     // First synchronizer stage.
  logic                  rx_sync;     // Synchronized line.
  logic                  rx_prev;     // Line one clock earlier.
  logic [BAUD_CNT_W-1:0] baud_cnt;    // Clocks within the current bit.
  logic [BIT_CNT_W-1:0]  bit_cnt;     // Data bits sampled so far.
  logic [7:0]            rx_shft;     // Incoming data.
  logic                  start_edge;  // Falling edge on the line.
  logic                  half_tick;   // Middle of the start bit.
  logic                  bit_tick;    // Middle of a data or stop bit.
  logic                  sample;      // Shift in the line.
  logic                  set_rdy;     // Stop bit reached.

  //////////////////////////////////////////////////////////////////////////
  // Synchronizer and edge detect
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;                    // Preset to the idle level.
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev & ~rx_sync;
  assign half_tick  = (baud_cnt == BAUD_CNT_W'(HALF_BAUD - 1));
  assign bit_tick   = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  //////////////////////////////////////////////////////////////////////////
  // Receive FSM
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= RX_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    sample    = 1'b0;
    set_rdy   = 1'b0;
    case (state)
      RX_START: if (half_tick)
        nxt_state = rx_sync ? RX_IDLE : RX_DATA;   // High again means a glitch.
      RX_DATA: if (bit_tick) begin
        sample = 1'b1;
        if (bit_cnt == BIT_CNT_W'(7))
          nxt_state = RX_STOP;            // Eighth data bit taken.
      end
      RX_STOP: if (bit_tick) begin
        set_rdy   = 1'b1;
        nxt_state = RX_IDLE;
      end
      default: if (start_edge)
        nxt_state = RX_START;
    endcase
  end

  // Bit timer restarts on every state change and every sample point.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (state == RX_IDLE || nxt_state != state || bit_tick)
      baud_cnt <= '0;
    else
      baud_cnt <= baud_cnt + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (state != RX_DATA)
      bit_cnt <= '0;
    else if (sample)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (sample)
      rx_shft <= {rx_sync, rx_shft[7:1]}; // LSB arrives first.
  end

  assign rx_data = rx_shft;

  // Ready flag. Cleared by the user or by the next start bit.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rx_rdy <= 1'b0;
    else if (clr_rx_rdy || state == RX_START)
      rx_rdy <= 1'b0;
    else if (set_rdy)
      rx_rdy <= 1'b1;
  end

  // A stale byte must never be visible while a new one is shifting in.
  rdy_not_in_data_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(rx_rdy && state == RX_DATA))
    else $error("uart_rx: rx_rdy high during data bits");

endmodule

`default_nettype wire

/* rtl/remote_comm.sv */
/*
  Command sender.
  Splits a 16-bit command into a high and a low byte, sends both over a UART
  transmitter and presents the one-byte response from the remote node.
*/
`timescale 1ns/1ps
`default_nettype none

module remote_comm
  import link_pkg::*;
(
  input  logic        clk,       // System clock.
  input  logic        rst_n,     // Asynchronous active low reset.
  input  logic        snd_cmd,   // Send cmd, one cycle.
  input  logic [15:0] cmd,       // Command, valid with snd_cmd.
  input  logic        rx,        // Serial line from the remote node.
  output logic        tx,        // Serial line to the remote node.
  output logic [7:0]  resp,      // Response byte.
  output logic        resp_rdy,  // Response arrived.
  output logic        cmd_snt    // Both bytes sent, held until next snd_cmd.
);

  snd_state_t state;        // Current state.
  snd_state_t nxt_state;    // Next state.
  logic       trmt;         // Start a byte.
  logic       tx_done;      // Byte finished.
  logic       sel_high;     // Send the high byte straight from cmd.
  logic       set_cmd_snt;  // Low byte finished.
  logic [7:0] low_byte;     // Low byte held for the second frame.
  logic [7:0] tx_byte;      // Byte into the transmitter.

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .trmt    (trmt),
    .tx_data (tx_byte),
    .tx      (tx),
    .tx_done (tx_done)
  );

  uart_rx u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .clr_rx_rdy (snd_cmd),        // A new command drops the old response.
    .rx_data    (resp),
    .rx_rdy     (resp_rdy)
  );

  always_ff @(posedge clk) begin
    if (snd_cmd)
      low_byte <= cmd[7:0];       // cmd is gone after this cycle.
  end

  assign tx_byte = sel_high ? cmd[15:8] : low_byte;

  //////////////////////////////////////////////////////////////////////////
  // Sender FSM
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= SND_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state   = state;
    sel_high    = 1'b0;
    trmt        = 1'b0;
    set_cmd_snt = 1'b0;
    case (state)
      SND_HIGH: if (tx_done) begin
        trmt      = 1'b1;             // Low byte follows at once.
        nxt_state = SND_LOW;
      end
      SND_LOW: if (tx_done) begin
        set_cmd_snt = 1'b1;
        nxt_state   = SND_IDLE;
      end
      default: if (snd_cmd) begin
        sel_high  = 1'b1;
        trmt      = 1'b1;             // High byte goes first.
        nxt_state = SND_HIGH;
      end
    endcase
  end

  // Command sent flag.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cmd_snt <= 1'b0;
    else if (snd_cmd)
      cmd_snt <= 1'b0;
    else if (set_cmd_snt)
      cmd_snt <= 1'b1;
  end

  // No back-pressure. A command may only start from idle.
  snd_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    snd_cmd |-> state == SND_IDLE)
    else $error("remote_comm: snd_cmd while a command is being sent");

endmodule

`default_nettype wire

/* rtl/cmd_receiver.sv */
/*
  Remote node side of the link.
  Assembles two received bytes into a 16-bit command, high byte first, and
  flags it. Sends a one-byte response on request.
*/
`timescale 1ns/1ps
`default_nettype none

module cmd_receiver
  import link_pkg::*;
(
  input  logic        clk,          // System clock.
  input  logic        rst_n,        // Asynchronous active low reset.
  input  logic        rx,           // Serial line from the sender.
  input  logic        clr_cmd_rdy,  // Command taken.
  input  logic        snd_resp,     // Send resp_data, one cycle.
  input  logic [7:0]  resp_data,    // Response byte, valid with snd_resp.
  output logic        tx,           // Serial line to the sender.
  output logic [15:0] rcv_cmd,      // Assembled command.
  output logic        cmd_rdy,      // Command complete.
  output logic        resp_snt      // Response out, held until next snd_resp.
);

  asm_state_t state;        // Current state.
  asm_state_t nxt_state;    // Next state.
  logic       rx_rdy;       // Byte arrived.
  logic       clr_rx_rdy;   // Byte consumed.
  logic [7:0] rx_data;      // Received byte.
  logic [7:0] high_byte;    // First half of the command.
  logic       load_high;    // Keep the first byte.
  logic       set_cmd_rdy;  // Second byte arrived.
  logic       tx_done;      // Response frame finished.
  logic       tx_used;      // Some response has gone out since reset.

  uart_rx u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .clr_rx_rdy (clr_rx_rdy),
    .rx_data    (rx_data),
    .rx_rdy     (rx_rdy)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .trmt    (snd_resp),
    .tx_data (resp_data),
    .tx      (tx),
    .tx_done (tx_done)
  );

  //////////////////////////////////////////////////////////////////////////
  // Command assembler
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= WAIT_HIGH;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state   = state;
    clr_rx_rdy  = 1'b0;
    load_high   = 1'b0;
    set_cmd_rdy = 1'b0;
    case (state)
      WAIT_LOW: if (rx_rdy) begin
        clr_rx_rdy  = 1'b1;
        set_cmd_rdy = 1'b1;           // Command is whole.
        nxt_state   = WAIT_HIGH;
      end
      default: if (rx_rdy) begin
        clr_rx_rdy = 1'b1;            // Each byte consumed on arrival.
        load_high  = 1'b1;
        nxt_state  = WAIT_LOW;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (load_high)
      high_byte <= rx_data;
    if (set_cmd_rdy)
      rcv_cmd <= {high_byte, rx_data};  // Overwrites an untaken command.
  end

  // Set wins so a command finishing with a clear is not lost.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cmd_rdy <= 1'b0;
    else if (set_cmd_rdy)
      cmd_rdy <= 1'b1;
    else if (clr_cmd_rdy)
      cmd_rdy <= 1'b0;
  end

  //////////////////////////////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      resp_snt <= 1'b0;
      tx_used  <= 1'b0;
    end else if (snd_resp) begin
      resp_snt <= 1'b0;
      tx_used  <= 1'b1;
    end else if (tx_done) begin
      resp_snt <= 1'b1;               // One cycle after tx_done.
    end
  end

  // After the first send, a new response waits for the previous one.
  resp_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    snd_resp && tx_used |-> resp_snt)
    else $error("cmd_receiver: snd_resp while a response is in flight");

endmodule

`default_nettype wire

/* rtl/comm_link.sv */
/*
  Top level of the serial command link.
  Command sender and remote node with their serial lines crossed.
*/
`timescale 1ns/1ps
`default_nettype none

module comm_link (
  input  logic        clk,          // System clock.
  input  logic        rst_n,        // Asynchronous active low reset.
  // Sender side.
  input  logic        snd_cmd,      // Send cmd.
  input  logic [15:0] cmd,          // Command to send.
  output logic [7:0]  resp,         // Response from the remote node.
  output logic        resp_rdy,     // Response arrived.
  output logic        cmd_snt,      // Command sent.
  // Remote node side.
  output logic [15:0] rcv_cmd,      // Command as received.
  output logic        cmd_rdy,      // Command complete.
  input  logic        clr_cmd_rdy,  // Command taken.
  input  logic        snd_resp,     // Send resp_data.
  input  logic [7:0]  resp_data,    // Response byte.
  output logic        resp_snt      // Response sent.
);

  logic cmd_line;   // Sender tx to node rx.
  logic resp_line;  // Node tx to sender rx.

  remote_comm u_sender (
    .clk(clk), .rst_n(rst_n), .snd_cmd(snd_cmd), .cmd(cmd),
    .rx(resp_line), .tx(cmd_line),
    .resp(resp), .resp_rdy(resp_rdy), .cmd_snt(cmd_snt)
  );

  cmd_receiver u_node (
    .clk(clk), .rst_n(rst_n), .rx(cmd_line), .clr_cmd_rdy(clr_cmd_rdy),
    .snd_resp(snd_resp), .resp_data(resp_data), .tx(resp_line),
    .rcv_cmd(rcv_cmd), .cmd_rdy(cmd_rdy), .resp_snt(resp_snt)
  );

endmodule

`default_nettype wire

/* verification/comm_link_tb.sv */
/*
  Directed testbench of the serial command link.
  Clock, reset, watchdog, compare tasks, strobe drivers and the test tasks
  for reset, single command, response path, flag clearing, random stream
  and command overwrite.
*/
`timescale 1ns/1ps
`default_nettype none

module comm_link_tb
  import link_pkg::*;
();

  localparam int CLK_PERIOD   = 10;                       // ns.
  localparam int FRAME_CYCLES = FRAME_BITS * BAUD_DIV;    // One byte on the line.
  localparam int WAIT_CYCLES  = 4 * FRAME_CYCLES;         // Bound of one flag wait.
  localparam int NUM_XFERS    = 29;                       // Bytes pairs and responses sent.
  localparam int WATCHDOG_NS  = (NUM_XFERS + 10) * 2 * FRAME_CYCLES * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        snd_cmd;
  logic [15:0] cmd;
  logic [7:0]  resp;
  logic        resp_rdy;
  logic        cmd_snt;
  logic [15:0] rcv_cmd;
  logic        cmd_rdy;
  logic        clr_cmd_rdy;
  logic        snd_resp;
  logic [7:0]  resp_data;
  logic        resp_snt;

  integer      seed;          // Random state.
  int          errors;        // Failed checks.
  int          tests_run;
  int          tests_failed;

  comm_link dut0 (
    .clk(clk), .rst_n(rst_n), .snd_cmd(snd_cmd), .cmd(cmd), .resp(resp),
    .resp_rdy(resp_rdy), .cmd_snt(cmd_snt), .rcv_cmd(rcv_cmd), .cmd_rdy(cmd_rdy),
    .clr_cmd_rdy(clr_cmd_rdy), .snd_resp(snd_resp), .resp_data(resp_data),
    .resp_snt(resp_snt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and flag waits
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_u16(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s expected 0x%04h got 0x%04h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_u8(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s expected 0x%02h got 0x%02h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch %s expected 0x%0h got 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  function automatic logic flag_value(input string name);
    case (name)
      "cmd_snt":  return cmd_snt;
      "cmd_rdy":  return cmd_rdy;
      "resp_rdy": return resp_rdy;
      "resp_snt": return resp_snt;
      default:    return 1'bx;
    endcase
  endfunction

  // Flags are sampled on the falling edge, away from the DUT's updates.
  task automatic wait_flag(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (flag_value(name) !== 1'b1 && cycles < WAIT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (flag_value(name) !== 1'b1) begin
      $display("ERROR: timeout waiting for %s", name);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Strobe drivers
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_command(input logic [15:0] value);
    @(posedge clk);
    snd_cmd <= 1'b1;
    cmd     <= value;
    @(posedge clk);
    snd_cmd <= 1'b0;
    cmd     <= 16'h0000;                  // Low byte must come from the register.
    @(negedge clk);
  endtask

  task automatic send_response(input logic [7:0] value);
    @(posedge clk);
    snd_resp  <= 1'b1;
    resp_data <= value;
    @(posedge clk);
    snd_resp  <= 1'b0;
    resp_data <= 8'h00;
    @(negedge clk);
  endtask

  task automatic clear_command();
    @(posedge clk);
    clr_cmd_rdy <= 1'b1;
    @(posedge clk);
    clr_cmd_rdy <= 1'b0;
    @(negedge clk);
  endtask

  // One command end to end, then the command is taken.
  task automatic command_round(input logic [15:0] value);
    send_command(value);
    wait_flag("cmd_rdy");
    check_u16("rcv_cmd", value, rcv_cmd);
    wait_flag("cmd_snt");
    clear_command();
    check_bit("cmd_rdy", 1'b0, cmd_rdy);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("[%s] passed", name);
    end else begin
      $display("[%s] failed with %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic reset_state();
    int e0;
    e0 = errors;
    check_bit("cmd_snt", 1'b0, cmd_snt);
    check_bit("resp_rdy", 1'b0, resp_rdy);
    check_bit("cmd_rdy", 1'b0, cmd_rdy);
    check_bit("resp_snt", 1'b0, resp_snt);
    report_test("reset_state", e0);
  endtask

  task automatic single_command();
    int e0;
    e0 = errors;
    command_round(16'hA53C);
    report_test("single_command", e0);
  endtask

  task automatic response_path();
    int          e0;
    logic [31:0] rnd;
    e0  = errors;
    rnd = $random(seed);
    send_response(rnd[7:0]);
    wait_flag("resp_rdy");
    check_u8("resp", rnd[7:0], resp);
    wait_flag("resp_snt");
    report_test("response_path", e0);
  endtask

  // Both flags are high from the previous tests; snd_cmd knocks them down.
  task automatic flag_clearing();
    int e0;
    e0 = errors;
    check_bit("cmd_snt", 1'b1, cmd_snt);
    check_bit("resp_rdy", 1'b1, resp_rdy);
    send_command(16'h3CC3);
    check_bit("cmd_snt", 1'b0, cmd_snt);
    check_bit("resp_rdy", 1'b0, resp_rdy);
    wait_flag("cmd_rdy");
    check_u16("rcv_cmd", 16'h3CC3, rcv_cmd);
    wait_flag("cmd_snt");
    clear_command();
    report_test("flag_clearing", e0);
  endtask

  task automatic random_stream();
    int          e0;
    logic [31:0] rnd;
    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      command_round(rnd[15:0]);
      send_response(rnd[23:16]);
      wait_flag("resp_rdy");
      check_u8("resp", rnd[23:16], resp);
      wait_flag("resp_snt");
    end
    report_test("random_stream", e0);
  endtask

  // The second command follows the first with no clr_cmd_rdy between them.
  task automatic overwrite_command();
    int   e0;
    int   cycles;
    logic dropped;
    e0 = errors;
    send_command(16'h1234);
    wait_flag("cmd_rdy");
    check_u16("rcv_cmd", 16'h1234, rcv_cmd);
    wait_flag("cmd_snt");
    send_command(16'hFEDC);
    dropped = 1'b0;                       // cmd_rdy must hold through the second command.
    cycles  = 0;
    while (cmd_snt !== 1'b1 && cycles < WAIT_CYCLES) begin
      if (cmd_rdy !== 1'b1)
        dropped = 1'b1;
      @(negedge clk);
      cycles++;
    end
    if (dropped) begin
      $display("ERROR: cmd_rdy dropped while the second command was in flight");
      errors++;
    end
    wait_flag("cmd_snt");
    check_bit("cmd_rdy", 1'b1, cmd_rdy);
    check_u16("rcv_cmd", 16'hFEDC, rcv_cmd);
    clear_command();
    report_test("overwrite_command", e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rst_n        = 1'b0;
    snd_cmd      = 1'b0;
    cmd          = 16'h0000;
    clr_cmd_rdy  = 1'b0;
    snd_resp     = 1'b0;
    resp_data    = 8'h00;
    seed         = 32'hf757_3e83;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_state();
    single_command();
    response_path();
    flag_clearing();
    random_stream();
    overwrite_command();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
rtl/link_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/remote_comm.sv
rtl/cmd_receiver.sv
rtl/comm_link.sv
verification/comm_link_tb.sv

/* Makefile */
# Verilator simulation of the serial command link.

TOP = comm_link_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
